/* source/adc_pkg.sv */
// ADC control shared definitions
package adc_pkg;

	//////////////////////////////////////////////////////////////
	// Host command word
	typedef struct packed {
		logic        trig;  // One-cycle command strobe
		logic [15:0] addr;  // High byte selects the function
		logic [15:0] data;
	} cmd_t;

	localparam logic [7:0] CMD_SPI_SET = 8'h31; // Write one SPI register
	localparam logic [7:0] CMD_PS_SET  = 8'h32; // Set encode phase target

	//////////////////////////////////////////////////////////////
	// SPI word, field view for building, raw view for shifting
	typedef struct packed {
		logic       rw;       // 0 = write
		logic [6:0] reg_addr;
		logic [7:0] reg_data;
	} spi_fields_t;

	typedef union packed {
		spi_fields_t f;
		logic [15:0] raw;
	} spi_word_u;

	// Power-up writes: soft reset, two's complement, two-lane mode
	localparam spi_word_u INIT_REGS [3] = '{16'h0080, 16'h0120, 16'h0200};

	//////////////////////////////////////////////////////////////
	// Clock manager phase shift pins
	typedef struct packed {
		logic psclk;
		logic psen;
		logic psincdec; // 1 = increment
	} ps_ctrl_t;

	typedef struct packed {
		logic done;
		logic locked;
	} ps_stat_t;

	// Deserialized bytes of one frame
	typedef struct packed {
		logic [7:0] d0_a, d0_b, d1_a, d1_b, fr;
	} lane_bytes_t;

	typedef enum logic [1:0] {CTL_WAIT, CTL_SEND, CTL_PULSE, CTL_IDLE} ctl_state_e;

	typedef enum logic [2:0] {
		PS_IDLE, PS_DECIDE, PS_CLK_HI, PS_RELEASE, PS_WAIT, PS_STEP
	} ps_state_e;

endpackage

/* source/adc_controller.sv */
// ADC configuration controller
module adc_controller import adc_pkg::*; #(
	parameter int INIT_WAIT = 255 // Cycles before the first write
) (
	input  logic      clk_in,
	input  logic      rst_in,
	input  cmd_t      cmd,
	input  logic      spi_ready,
	output spi_word_u spi_word,
	output logic      spi_trigger
);

	localparam int CNT_W = $clog2(INIT_WAIT + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(INIT_WAIT - 1);

	ctl_state_e       state;
	logic [CNT_W-1:0] wait_cnt;  // Power-up delay
	logic [1:0]       init_idx;  // Current INIT_REGS entry

	//////////////////////////////////////////////////////////////
	// Control FSM
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state       <= CTL_WAIT;
			wait_cnt    <= '0;
			init_idx    <= 2'd0;
			spi_trigger <= 1'b0;
			spi_word    <= '0;
		end else begin
			case (state)
				// Hold off until the ADC has settled
				CTL_WAIT: begin
					if (wait_cnt == CNT_LAST) begin
						spi_word <= INIT_REGS[0];
						state    <= CTL_SEND;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end

				// Word is loaded, fire once the shifter is free
				CTL_SEND: begin
					if (spi_ready) begin
						spi_trigger <= 1'b1;
						state       <= CTL_PULSE;
					end
				end

				// Trigger high this cycle only
				CTL_PULSE: begin
					spi_trigger <= 1'b0;
					if (init_idx < 2'd2) begin
						// Next power-up register
						init_idx <= init_idx + 1'b1;
						spi_word <= INIT_REGS[init_idx + 1'b1];
						state    <= CTL_SEND;
					end else begin
						state <= CTL_IDLE; // Later passes are host writes
					end
				end

				// Host register writes
				CTL_IDLE: begin
					if (cmd.trig && (cmd.addr[15:8] == CMD_SPI_SET)) begin
						spi_word.f.rw       <= 1'b0;           // Write
						spi_word.f.reg_addr <= cmd.addr[6:0];
						spi_word.f.reg_data <= cmd.data[7:0];
						state               <= CTL_SEND;
					end
				end

				default: state <= CTL_IDLE;
			endcase
		end
	end

endmodule

/* source/spi_master.sv */
// SPI write shifter
module spi_master import adc_pkg::*; #(
	parameter int SPI_CLK_DIV = 10 // System cycles per sck half period
) (
	input  logic      clk_in,
	input  logic      rst_in,
	input  spi_word_u word,
	input  logic      trigger,
	output logic      ready,
	output logic      scs,
	output logic      sck,
	output logic      sdo
);

	localparam int DIV_W = (SPI_CLK_DIV > 1) ? $clog2(SPI_CLK_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SPI_CLK_DIV - 1);
	localparam logic [4:0] N_BITS = 5'd16;

	logic             busy;     // Frame in progress
	logic [15:0]      shreg;    // MSB is on the wire
	logic [DIV_W-1:0] div_cnt;  // Half period divider
	logic [4:0]       bit_cnt;  // Falling edges so far

	assign ready = ~busy;
	assign scs   = ~busy;   // Chip select low for the whole frame
	assign sdo   = shreg[15];

	//////////////////////////////////////////////////////////////
	// Frame sequencer
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			busy    <= 1'b0;
			shreg   <= '0;     // Keeps sdo low when idle
			sck     <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (!busy) begin
			if (trigger) begin
				busy    <= 1'b1;
				shreg   <= word.raw; // First bit out at frame start
				div_cnt <= '0;
				bit_cnt <= '0;
			end
		end else if (div_cnt == DIV_LAST) begin
			div_cnt <= '0;
			if (sck) begin
				// Falling edge, next bit onto sdo
				sck     <= 1'b0;
				shreg   <= {shreg[14:0], 1'b0};
				bit_cnt <= bit_cnt + 5'd1;
			end else if (bit_cnt == N_BITS) begin
				busy <= 1'b0; // Half period after the last fall
			end else begin
				sck <= 1'b1;  // Receiver samples here
			end
		end else begin
			div_cnt <= div_cnt + DIV_W'(1);
		end
	end

endmodule

/* source/phase_stepper.sv */
// Encode phase stepper
module phase_stepper import adc_pkg::*; #(
	parameter int PS_RESET_VALUE  = 256,
	parameter int PS_RESET_TARGET = 380,
	parameter int PS_MIN          = 0,
	parameter int PS_MAX          = 511
) (
	input  logic     clk_in,
	input  logic     rst_in,
	input  cmd_t     cmd,
	input  ps_stat_t ps_stat,
	output ps_ctrl_t ps_ctrl
);

	localparam logic [8:0] VAL_MIN = 9'(PS_MIN);
	localparam logic [8:0] VAL_MAX = 9'(PS_MAX);

	ps_state_e  state;
	logic [8:0] value;   // Current shifter position
	logic [8:0] target;  // Requested position

	//////////////////////////////////////////////////////////////
	// Stepping FSM
	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			state   <= PS_DECIDE;   // Walk to the reset target once locked
			value   <= 9'(PS_RESET_VALUE);
			target  <= 9'(PS_RESET_TARGET);
			ps_ctrl <= '0;
		end else begin
			case (state)
				PS_IDLE: begin
					ps_ctrl <= '0;
					if (cmd.trig && (cmd.addr[15:8] == CMD_PS_SET)) begin
						target <= cmd.data[8:0];
						state  <= PS_DECIDE;
					end
				end

				// Pick a direction, or stop at target or limit
				PS_DECIDE: begin
					if (ps_stat.locked) begin
						if ((target > value) && (value < VAL_MAX)) begin
							ps_ctrl.psen     <= 1'b1;
							ps_ctrl.psincdec <= 1'b1; // Up
							state            <= PS_CLK_HI;
						end else if ((target < value) && (value > VAL_MIN)) begin
							ps_ctrl.psen     <= 1'b1;
							ps_ctrl.psincdec <= 1'b0; // Down
							state            <= PS_CLK_HI;
						end else begin
							state <= PS_IDLE;
						end
					end
				end

				PS_CLK_HI: begin
					ps_ctrl.psclk <= 1'b1;
					state         <= PS_RELEASE;
				end

				// psen has now been high for two cycles
				PS_RELEASE: begin
					ps_ctrl.psen  <= 1'b0;
					ps_ctrl.psclk <= 1'b0;
					state         <= PS_WAIT;
				end

				// Keep psclk running until the shift completes
				PS_WAIT: begin
					ps_ctrl.psclk <= ~ps_ctrl.psclk;
					if (ps_stat.done)
						state <= PS_STEP;
				end

				PS_STEP: begin
					ps_ctrl.psclk <= 1'b0;
					value <= ps_ctrl.psincdec ? value + 9'd1 : value - 9'd1;
					state <= PS_DECIDE;
				end

				default: state <= PS_IDLE;
			endcase
		end
	end

endmodule

/* source/lane_reorder.sv */
// ADC lane reorder
module lane_reorder import adc_pkg::*; (
	input  logic               clk_in,
	input  logic               rst_in,
	input  lane_bytes_t        lanes,
	output logic signed [15:0] adc0,
	output logic signed [15:0] adc1,
	output logic        [7:0]  frame
);

	// Two lanes per channel, bits alternate starting from lane a
	function automatic logic signed [15:0] interleave(input logic [7:0] a, input logic [7:0] b);
		logic signed [15:0] s;
		for (int k = 0; k < 8; k++) begin
			s[15 - 2*k] = a[k];
			s[14 - 2*k] = b[k];
		end
		return s;
	endfunction

	always_ff @(posedge clk_in or posedge rst_in) begin
		if (rst_in) begin
			adc0  <= '0;
			adc1  <= '0;
			frame <= '0;
		end else begin
			adc0  <= interleave(lanes.d0_a, lanes.d0_b);
			adc1  <= interleave(lanes.d1_a, lanes.d1_b);
			frame <= lanes.fr; // Frame byte as is
		end
	end

endmodule

/* source/ltc2195_top.sv */
// LTC2195 control core
module ltc2195_top import adc_pkg::*; #(
	parameter int SPI_CLK_DIV     = 10,
	parameter int INIT_WAIT       = 255,
	parameter int PS_RESET_VALUE  = 256,
	parameter int PS_RESET_TARGET = 380,
	parameter int PS_MIN          = 0,
	parameter int PS_MAX          = 511
) (
	input  logic               clk_in,
	input  logic               rst_in,
	input  cmd_t               cmd,
	input  ps_stat_t           ps_stat,
	input  lane_bytes_t        lanes,
	output logic               spi_scs,
	output logic               spi_sck,
	output logic               spi_sdo,
	output ps_ctrl_t           ps_ctrl,
	output logic signed [15:0] adc0,
	output logic signed [15:0] adc1,
	output logic        [7:0]  frame
);

	////////////////////////////////////////////////////////////
	// Configuration path
	spi_word_u spi_word;
	logic      spi_trigger;
	logic      spi_ready;  // Shifter idle

	adc_controller #(.INIT_WAIT(INIT_WAIT)) u_ctrl (
		.clk_in, .rst_in, .cmd, .spi_ready, .spi_word, .spi_trigger
	);

	spi_master #(.SPI_CLK_DIV(SPI_CLK_DIV)) u_spi (
		.clk_in, .rst_in, .word(spi_word), .trigger(spi_trigger), .ready(spi_ready),
		.scs(spi_scs), .sck(spi_sck), .sdo(spi_sdo)
	);

	////////////////////////////////////////////////////////////
	// Encode phase and sample data
	phase_stepper #(
		.PS_RESET_VALUE(PS_RESET_VALUE), .PS_RESET_TARGET(PS_RESET_TARGET),
		.PS_MIN(PS_MIN), .PS_MAX(PS_MAX)
	) u_ps (.clk_in, .rst_in, .cmd, .ps_stat, .ps_ctrl);

	lane_reorder u_lanes (.clk_in, .rst_in, .lanes, .adc0, .adc1, .frame);

endmodule

/* tb/tb_top.sv */
// LTC2195 control core testbench
module tb_top import adc_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int SPI_CLK_DIV = 10;
	localparam int INIT_WAIT   = 255;
	localparam int N_FRAMES    = 8;     // SPI frames in the stimulus, rounded up
	localparam int N_STEPS     = 1100;  // Phase steps in the stimulus, rounded up
	localparam int TIMEOUT     = INIT_WAIT + N_FRAMES * (2 * 16 * SPI_CLK_DIV + 40)
		+ N_STEPS * 10 + 2000;

	logic clk_in, rst_in;
	cmd_t cmd;
	ps_stat_t ps_stat = '0;
	lane_bytes_t lanes;
	logic spi_scs, spi_sck, spi_sdo;
	ps_ctrl_t ps_ctrl;
	logic signed [15:0] adc0, adc1;
	logic [7:0] frame;

	int cycle = 0, rel_cycle = 0;            // Clock count, reset release
	int errors = 0, tests = 0, failed = 0, err_mark = 0;
	int up_cnt = 0, down_cnt = 0, lock_cnt = 0, done_cnt = 0;
	logic psen_q = 1'b0;
	logic [15:0] shift;
	int nbits = 0, start_cyc = 0;
	logic [15:0] frame_q[$];                 // Received SPI words
	int start_q[$];                          // Cycle each frame began
	logic [31:0] lcg_state = 32'hfeb2cf0f;

	ltc2195_top #(.SPI_CLK_DIV(SPI_CLK_DIV), .INIT_WAIT(INIT_WAIT), .PS_RESET_VALUE(256),
		.PS_RESET_TARGET(380), .PS_MIN(0), .PS_MAX(511)) u_dut (.*);

	always #10 clk_in = ~clk_in;

	always @(posedge clk_in) begin
		cycle++;
		if (cycle > TIMEOUT) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////
	// Clock manager model
	always @(negedge clk_in) begin
		if (rst_in) lock_cnt = 0;
		else if (lock_cnt < 20) lock_cnt++;
		ps_stat.locked <= (lock_cnt >= 20);
		ps_stat.done   <= (done_cnt == 1);                // One-cycle done
		if (done_cnt > 0) done_cnt--;
		if (psen_q && !ps_ctrl.psen) done_cnt = 3;       // Shift takes 3 cycles
		if (!psen_q && ps_ctrl.psen) begin
			if (ps_ctrl.psincdec) up_cnt++;
			else down_cnt++;
		end
		// psclk low in the first psen cycle, high in the second
		if (ps_ctrl.psen) check("psclk", {31'h0, ps_ctrl.psclk}, {31'h0, psen_q});
		psen_q = ps_ctrl.psen;
	end

	//////////////////////////////////////////////////////////////
	// SPI monitor
	always @(negedge spi_scs) begin
		nbits = 0;
		start_cyc = cycle;
	end

	always @(posedge spi_sck) if (!spi_scs) begin
		shift = {shift[14:0], spi_sdo};  // Sampled on the rising edge
		nbits++;
	end

	always @(posedge spi_scs) begin
		if (nbits == 16) begin
			frame_q.push_back(shift);
			start_q.push_back(start_cyc);
		end else if (nbits != 0) begin
			$display("SPI frame at %0t ended after %0d bits instead of 16", $time, nbits);
			errors++;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Output bit j comes from lane a when odd, lane b when even
	function automatic logic [15:0] expect_sample(input logic [7:0] a, input logic [7:0] b);
		logic [15:0] r;
		for (int j = 0; j < 16; j++)
			r[j] = (j % 2) ? a[(15 - j) / 2] : b[(14 - j) / 2];
		return r;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_fields(input int got, input int want);
		if (got != want) begin
			$display("Stimulus line has %0d fields instead of %0d", got, want);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors > err_mark) failed++;
		$display("Test %0d %s: %s", tests, name, (errors > err_mark) ? "failed" : "ok");
		err_mark = errors;
	endtask

	task automatic wait_phase_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 40) begin
			@(negedge clk_in);
			if (ps_ctrl.psen || !ps_stat.locked) quiet = 0;
			else quiet++;
		end
	endtask

	task automatic wait_spi_quiet();
		int quiet;
		quiet = 0;
		while (quiet < 2 * SPI_CLK_DIV) begin
			@(negedge clk_in);
			quiet = spi_scs ? quiet + 1 : 0;
		end
	endtask

	task automatic send_cmd(input logic [15:0] a, input logic [15:0] d);
		cmd = '{trig: 1'b1, addr: a, data: d};
		@(negedge clk_in);
		cmd.trig = 1'b0;                 // Strobe lasts one cycle
	endtask

	task automatic lane_test(input logic [7:0] b[5], input logic [15:0] e0,
		input logic [15:0] e1, input logic [7:0] ef);
		lanes = '{d0_a: b[0], d0_b: b[1], d1_a: b[2], d1_b: b[3], fr: b[4]};
		@(negedge clk_in);               // Registered once
		check("adc0", {16'h0, adc0}, {16'h0, e0});
		check("adc1", {16'h0, adc1}, {16'h0, e1});
		check("frame", {24'h0, frame}, {24'h0, ef});
	endtask

	//////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		int fd, rc, a, d, steps, base;
		byte kind;
		logic [8*128-1:0] rest;
		logic [7:0] lb[5];
		logic [15:0] e0, e1, w;
		logic first;
		clk_in = 1'b0;
		rst_in = 1'b1;
		cmd = '0;
		lanes = '0;
		first = 1'b1;
		base = 0;
		repeat (3) @(negedge clk_in);
		check("spi_scs", {31'h0, spi_scs}, 1);
		check("spi_sck", {31'h0, spi_sck}, 0);
		check("psen", {31'h0, ps_ctrl.psen}, 0);
		check("adc_out", {adc0, adc1}, 0);
		check("frame", {24'h0, frame}, 0);
		repeat (2) @(negedge clk_in);
		rst_in = 1'b0;
		rel_cycle = cycle;
		@(negedge clk_in);
		check("spi_scs", {31'h0, spi_scs}, 1);
		check("spi_sck", {31'h0, spi_sck}, 0);
		check("spi_sdo", {31'h0, spi_sdo}, 0);
		check("psen", {31'h0, ps_ctrl.psen}, 0);
		check("psclk", {31'h0, ps_ctrl.psclk}, 0);
		check("psincdec", {31'h0, ps_ctrl.psincdec}, 0);
		check("adc_out", {adc0, adc1}, 0);
		check("frame", {24'h0, frame}, 0);
		end_test("reset state");
		fd = $fopen("tb/adc_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tb/adc_stimulus.txt");
			errors++;
		end else begin
			while ($fscanf(fd, " %c", kind) == 1) begin
				case (kind)
					"#": rc = $fgets(rest, fd);     // Comment line
					"C": begin
						rc = $fscanf(fd, "%h %h", a, d);
						check_fields(rc, 2);
						wait_spi_quiet();
						send_cmd(a[15:0], d[15:0]);
					end
					"E": begin
						rc = $fscanf(fd, "%h", w);
						check_fields(rc, 1);
						while (frame_q.size() == 0) @(negedge clk_in);
						check("spi_word", {16'h0, frame_q.pop_front()}, {16'h0, w});
						if (first) check("first_frame_after_wait",
							{31'h0, (start_q[0] - rel_cycle) >= INIT_WAIT}, 1);
						void'(start_q.pop_front());
						first = 1'b0;
						end_test("spi frame");
					end
					"L": begin
						rc = $fscanf(fd, "%h %h %h %h %h %h %h %h",
							lb[0], lb[1], lb[2], lb[3], lb[4], e0, e1, d);
						check_fields(rc, 8);
						lane_test(lb, e0, e1, d[7:0]);
						end_test("lane vector");
					end
					"P": begin
						rc = $fscanf(fd, "%h %d", d, steps);
						check_fields(rc, 2);
						wait_phase_quiet();
						send_cmd({CMD_PS_SET, 8'h00}, d[15:0]);
						wait_phase_quiet();
						check("phase_steps", (up_cnt - down_cnt) - base, steps);
						base = up_cnt - down_cnt;
						end_test("phase steps");
					end
					default: begin
						$display("Unknown record letter %c in the stimulus file", kind);
						errors++;
					end
				endcase
			end
			$fclose(fd);
		end
		// Random lane vectors
		for (int n = 0; n < 16; n++) begin
			for (int i = 0; i < 5; i++) begin
				lcg_state = lcg_next(lcg_state);
				lb[i] = lcg_state[23:16];
			end
			lane_test(lb, expect_sample(lb[0], lb[1]), expect_sample(lb[2], lb[3]), lb[4]);
		end
		end_test("random lanes");
		wait_spi_quiet();
		check("extra_spi_frames", frame_q.size(), 0);
		end_test("no extra frames");
		$display("Tests: %0d, failed tests: %0d, errors: %0d", tests, failed, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tb/adc_stimulus.txt */
# E word | C addr data | L d0_a d0_b d1_a d1_b fr adc0 adc1 frame | P target steps
# All fields hex except the signed decimal step count
E 0080
E 0120
E 0200
C 3145 00a7
E 45a7
C 3512 0033
C 317f 00ff
E 7fff
C 3100 0000
E 0000
P 17c 124
P 100 -124
P 1ff 255
P 000 -511
L ff 00 00 ff a5 aaaa 5555 a5
L 01 00 00 80 3c 8000 0001 3c
L 0f f0 80 01 00 aa55 4002 00

/* tb.f */
source/adc_pkg.sv
source/adc_controller.sv
source/spi_master.sv
source/phase_stepper.sv
source/lane_reorder.sv
source/ltc2195_top.sv
tb/tb_top.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_top -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TESTS PASSED"; then
	exit 0
fi
exit 1
